//--- design/pps_event_if.sv
// ##########################################################
// pps event interface
// qualified pps edge and nudge strobes, decode to execute
// ##########################################################

`timescale 1ns/10ps

interface pps_event_if;

  logic pps_edge;   // synchronized pps rise, one cycle
  logic edge_ok;    // interval in window, valid with pps_edge
  logic nudge_up;   // faster button pressed
  logic nudge_down; // slower button pressed

  modport decode
  (
    output pps_edge,
    output edge_ok,
    output nudge_up,
    output nudge_down
  );

  modport execute
  (
    input pps_edge,
    input edge_ok,
    input nudge_up,
    input nudge_down
  );

  // output stage only cares about edge quality
  modport result
  (
    input pps_edge,
    input edge_ok
  );

endinterface

//--- design/pps_qualifier.sv
// ##########################################################
// pps qualifier
// synchronizes pps and nudge buttons, makes rise strobes
// and judges the pps interval against the tolerance window
// ##########################################################

`timescale 1ns/10ps

module pps_qualifier
(
  input  logic         clk,
  input  logic         reset,
  input  logic         pps,    // rising edge sensitive
  input  logic         faster, // nudge button
  input  logic         slower, // nudge button
  pps_event_if.decode  ev
);
  import pps_sync_pkg::*;

  // bit 0 pps, bit 1 faster, bit 2 slower
  logic [2:0] in_s1;     // first synchronizer stage
  logic [2:0] in_s2;     // second synchronizer stage
  logic [2:0] in_s3;     // previous synchronized level
  logic [2:0] rise;

  interval_t  ivl_cnt;   // clocks since last pps rise
  logic       seen_edge; // at least one pps rise since reset
  logic       in_window;

  assign rise = in_s2 & ~in_s3;

  // 3980..4020 accepted
  assign in_window = (ivl_cnt >= interval_t'(pps_period_cycles - pps_tol_cycles)) &&
                     (ivl_cnt <= interval_t'(pps_period_cycles + pps_tol_cycles));

  // two-flop synchronizers plus one level for edge detect
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      in_s1 <= '0;
      in_s2 <= '0;
      in_s3 <= '0;
    end
    else
    begin
      in_s1 <= {slower, faster, pps};
      in_s2 <= in_s1;
      in_s3 <= in_s2;
    end
  end

  // interval counter, restarts at each pps rise
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ivl_cnt   <= '0;
      seen_edge <= 1'b0;
    end
    else
    begin
      if (rise[0])
        ivl_cnt <= interval_t'(1); // rise cycle counts as 0
      else if (ivl_cnt != '1)
        ivl_cnt <= ivl_cnt + interval_t'(1); // saturate on lost pps
      if (rise[0])
        seen_edge <= 1'b1;
    end
  end

  // registered strobes, 3 cycles after the input rise
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ev.pps_edge   <= 1'b0;
      ev.edge_ok    <= 1'b0;
      ev.nudge_up   <= 1'b0;
      ev.nudge_down <= 1'b0;
    end
    else
    begin
      ev.pps_edge   <= rise[0];
      // first edge has no measured interval
      ev.edge_ok    <= rise[0] & seen_edge & in_window;
      ev.nudge_up   <= rise[1];
      ev.nudge_down <= rise[2];
    end
  end

endmodule

//--- design/pps_sync_pkg.sv
// ##########################################################
// pps sync package
// timing constants and word types shared by the
// pps-disciplined sample clock generator
// ##########################################################

package pps_sync_pkg;

  // simulation scaling: 4000 clocks per second, 100 sync periods
  localparam int pps_period_cycles = 4000; // nominal clocks between pps edges
  localparam int pps_tol_cycles    = 20;   // +- accepted interval deviation
  localparam int sync_div          = 40;   // clocks per sync period
  localparam int corr_step         = 2;    // max phase correction per good pps

  // consecutive good, zero-phase edges before pps_valid goes high
  localparam int lock_count        = 3;

  // phase word must hold 0..sync_div-1 with headroom
  localparam int phase_w           = 8;

  // interval counter saturates at 8191, well above the window
  localparam int interval_w        = 13;

  typedef logic [phase_w-1:0]    phase_t;    // sync phase
  typedef logic [interval_w-1:0] interval_t; // clocks since last pps edge

endpackage

//--- design/pps_sync_top.sv
// ##########################################################
// pps sync top
// pps-disciplined sample clock: qualifier, phase counter
// and output stage
// ##########################################################

`timescale 1ns/10ps

module pps_sync_top
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pps,       // gps pps, rising edge
  input  logic                 faster,    // nudge sync earlier
  input  logic                 slower,    // nudge sync later
  output logic                 sync_out,  // sample clock to sensor
  output logic                 pps_valid, // locked to pps
  output pps_sync_pkg::phase_t phase      // phase at last pps
);

  pps_event_if  ev_if ();
  sync_phase_if sp_if ();

  // decode, input qualification
  pps_qualifier u_qualifier
  (
    .clk    (clk),
    .reset  (reset),
    .pps    (pps),
    .faster (faster),
    .slower (slower),
    .ev     (ev_if.decode)
  );

  // execute, phase counter with correction
  sync_phase_counter u_phase_counter
  (
    .clk   (clk),
    .reset (reset),
    .ev    (ev_if.execute),
    .sp    (sp_if.execute)
  );

  // result, sync shaping and lock
  sync_output_stage u_output_stage
  (
    .clk       (clk),
    .reset     (reset),
    .ev        (ev_if.result),
    .sp        (sp_if.result),
    .sync_out  (sync_out),
    .pps_valid (pps_valid),
    .phase     (phase)
  );

endmodule

//--- design/sync_output_stage.sv
// ##########################################################
// sync output stage
// shapes the sync square wave, tracks pps lock and holds
// the phase captured at the last pps edge
// ##########################################################

`timescale 1ns/10ps

module sync_output_stage
(
  input  logic                 clk,
  input  logic                 reset,
  pps_event_if.result          ev,
  sync_phase_if.result         sp,
  output logic                 sync_out,  // drdy/sync pin
  output logic                 pps_valid, // lock flag
  output pps_sync_pkg::phase_t phase      // phase at last pps
);
  import pps_sync_pkg::*;

  phase_t hi_cnt;   // remaining high cycles after this one
  phase_t lock_cnt; // consecutive good zero-phase edges
  logic   ok_hold;  // edge_ok kept until capture
  logic   good_cap;

  assign good_cap = ok_hold && (sp.captured_phase == '0);

  // 50 % square wave, high for sync_div/2 cycles after tick
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sync_out <= 1'b0;
      hi_cnt   <= '0;
    end
    else if (sp.tick)
    begin
      sync_out <= 1'b1;
      hi_cnt   <= phase_t'(sync_div / 2 - 1);
    end
    else if (hi_cnt != '0)
      hi_cnt <= hi_cnt - phase_t'(1);
    else
      sync_out <= 1'b0;
  end

  // edge quality, one cycle ahead of capture
  always_ff @(posedge clk)
  begin
    if (reset)
      ok_hold <= 1'b0;
    else if (ev.pps_edge)
      ok_hold <= ev.edge_ok;
  end

  // lock tracking and phase report
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      phase     <= '0;
      lock_cnt  <= '0;
      pps_valid <= 1'b0;
    end
    else if (sp.capture)
    begin
      phase <= sp.captured_phase;
      if (good_cap)
      begin
        if (lock_cnt != phase_t'(lock_count))
          lock_cnt <= lock_cnt + phase_t'(1); // saturate at lock_count
        if (lock_cnt >= phase_t'(lock_count - 1))
          pps_valid <= 1'b1;
      end
      else
      begin
        // bad interval or phase off zero
        lock_cnt  <= '0;
        pps_valid <= 1'b0;
      end
    end
  end

endmodule

//--- design/sync_phase_counter.sv
// ##########################################################
// sync phase counter
// divides clk into sync periods, captures phase at pps and
// steers it toward zero by bounded holds and advances
// ##########################################################

`timescale 1ns/10ps

module sync_phase_counter
(
  input  logic          clk,
  input  logic          reset,
  pps_event_if.execute  ev,
  sync_phase_if.execute sp
);
  import pps_sync_pkg::*;

  // positive: advance cycles, negative: hold cycles
  typedef logic signed [phase_w:0] corr_t;

  corr_t  pend;      // pending correction
  corr_t  pend_left; // pending after this cycle's step
  corr_t  pps_corr;  // correction from the phase at this edge
  corr_t  pend_d;
  phase_t phase_d;
  logic   wrap;

  // error is the phase seen at the pps edge
  always_comb
  begin
    int err;
    int step;
    err = int'(sp.phase);
    if (err == 0)
      step = 0; // on time
    else if (err < sync_div / 2)
      step = -((err < corr_step) ? err : corr_step); // sync early, hold
    else
      step = ((sync_div - err) < corr_step) ? (sync_div - err) : corr_step; // late
    pps_corr = corr_t'(step);
  end

  // phase step for this cycle
  always_comb
  begin
    phase_d   = sp.phase + phase_t'(1);
    pend_left = pend;
    wrap      = (sp.phase == phase_t'(sync_div - 1));
    if (pend > 0)
    begin
      // advance, step by two and tick once on wrap
      pend_left = pend - corr_t'(1);
      wrap      = (sp.phase >= phase_t'(sync_div - 2));
      if (wrap)
        phase_d = sp.phase + phase_t'(2) - phase_t'(sync_div);
      else
        phase_d = sp.phase + phase_t'(2);
    end
    else if (pend < 0)
    begin
      pend_left = pend + corr_t'(1);
      phase_d   = sp.phase; // hold, no advance
      wrap      = 1'b0;
    end
    else if (wrap)
      phase_d = '0;
  end

  // new pps correction replaces, nudges accumulate
  always_comb
  begin
    if (ev.pps_edge && ev.edge_ok)
      pend_d = pps_corr;
    else
      pend_d = pend_left;
    if (ev.nudge_up)
      pend_d = pend_d + corr_t'(1);
    if (ev.nudge_down)
      pend_d = pend_d - corr_t'(1);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sp.phase   <= '0;
      sp.tick    <= 1'b0;
      sp.capture <= 1'b0;
      pend       <= '0;
    end
    else
    begin
      sp.phase   <= phase_d;
      sp.tick    <= wrap;        // high while phase shows the wrapped value
      sp.capture <= ev.pps_edge; // good or bad edge both reported
      pend       <= pend_d;      // applies from the next cycle
    end
  end

  // phase as seen in the edge cycle
  always_ff @(posedge clk)
  begin
    if (ev.pps_edge)
      sp.captured_phase <= sp.phase;
  end

endmodule

//--- design/sync_phase_if.sv
// ##########################################################
// sync phase interface
// tick, running phase and pps capture, execute to result
// ##########################################################

`timescale 1ns/10ps

interface sync_phase_if;
  import pps_sync_pkg::*;

  logic   tick;           // phase wrapped to zero
  phase_t phase;          // running phase, 0..sync_div-1
  logic   capture;        // one cycle after pps_edge
  phase_t captured_phase; // phase at the edge cycle

  // phase is read back by the counter itself
  modport execute
  (
    output tick,
    output phase,
    output capture,
    output captured_phase
  );

  modport result
  (
    input tick,
    input capture,
    input captured_phase
  );

endinterface

//--- flist.f
design/pps_sync_pkg.sv
design/pps_event_if.sv
design/sync_phase_if.sv
design/pps_qualifier.sv
design/sync_phase_counter.sv
design/sync_output_stage.sv
design/pps_sync_top.sv
sim/tb_pps_sync.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pps sync testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_pps_sync -o sim_pps_sync
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_pps_sync)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi

//--- sim/pps_sync_stim.txt
# name interval nudge exp_phase exp_valid
# nudge 0 none, 1 faster, 2 slower, pressed 1000 cycles into the interval
first_edge 137 0 20 0
pull_02 4000 0 20 0
pull_03 4000 0 22 0
pull_04 4000 0 24 0
pull_05 4000 0 26 0
pull_06 4000 0 28 0
pull_07 4000 0 30 0
pull_08 4000 0 32 0
pull_09 4000 0 34 0
pull_10 4000 0 36 0
pull_11 4000 0 38 0
zero_1 4000 0 0 0
zero_2 4000 0 0 0
lock 4000 0 0 1
locked 4000 0 0 1
bad_interval 3962 0 2 0
recover_1 4000 0 2 0
recover_2 4000 0 0 0
recover_3 4000 0 0 0
relock 4000 0 0 1
nudge_fast 4000 1 1 0
nudge_slow 4000 2 39 0
settle_1 4000 0 0 0
settle_2 4000 0 0 0
final_lock 4000 0 0 1

//--- sim/tb_pps_sync.sv
// ##########################################################
// pps sync testbench
// replays pps intervals and nudges from the stimulus file,
// checks captured phase, lock flag and sync waveform
// ##########################################################

`timescale 1ns/10ps

module tb_pps_sync;
  import pps_sync_pkg::*;

  localparam int max_lines     = 64;
  localparam int margin_cycles = 120; // tolerance window plus check slack

  logic   clk;
  logic   reset;
  logic   pps;
  logic   faster;
  logic   slower;
  logic   sync_out;
  logic   pps_valid;
  phase_t phase;

  // stimulus table
  logic [8*16-1:0] names [max_lines];
  int              ivls [max_lines];   // clocks to next pps rise
  int              nudges [max_lines]; // 0 none, 1 faster, 2 slower
  phase_t          exp_phase [max_lines];
  logic            exp_valid [max_lines];
  int              n_lines = 0;

  int              errors = 0;      // main sequence checks
  int              rate_errors = 0; // waveform monitor checks
  int              cycles = 0;
  int              limit = 0;       // 0 until the table is loaded
  int              rise_total = 0;  // sync_out rises since start
  int              hi_len = 0;
  logic            prev_sync = 1'b0;
  logic            rate_on = 1'b0;  // interval with no correction pending
  logic [8*16-1:0] cur_name = "none";

  pps_sync_top dut
  (
    .clk       (clk),
    .reset     (reset),
    .pps       (pps),
    .faster    (faster),
    .slower    (slower),
    .sync_out  (sync_out),
    .pps_valid (pps_valid),
    .phase     (phase)
  );

  always #20 clk = ~clk; // 40 ns period

  // watchdog on total run length
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (limit != 0 && cycles > limit)
    begin
      $display("timeout, run still going after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // sync rises and high time, sampled mid cycle
  always @(negedge clk)
  begin
    if (sync_out && !prev_sync)
    begin
      rise_total = rise_total + 1;
      hi_len     = 1;
    end
    else if (sync_out)
      hi_len = hi_len + 1;
    else if (prev_sync && rate_on && hi_len != sync_div / 2)
    begin
      $display("error %0s high_time expected %0d actual %0d", cur_name, sync_div / 2, hi_len);
      rate_errors = rate_errors + 1;
    end
    prev_sync = sync_out;
  end

  // lines that do not scan as five fields are comments
  task read_stim();
    int              fd;
    int              ret;
    int              f_ivl;
    int              f_nudge;
    int              f_phase;
    int              f_valid;
    logic [8*16-1:0] f_name;
    logic [8*128-1:0] line_text;
    fd = $fopen("sim/pps_sync_stim.txt", "r");
    if (fd == 0)
      $display("cannot open stimulus file sim/pps_sync_stim.txt");
    else
    begin
      while (!$feof(fd) && n_lines < max_lines)
      begin
        ret = $fgets(line_text, fd);
        if (ret > 0)
        begin
          ret = $sscanf(line_text, "%s %d %d %d %d", f_name, f_ivl, f_nudge, f_phase, f_valid);
          if (ret == 5)
          begin
            names[n_lines]     = f_name;
            ivls[n_lines]      = f_ivl;
            nudges[n_lines]    = f_nudge;
            exp_phase[n_lines] = phase_t'(f_phase);
            exp_valid[n_lines] = 1'(f_valid);
            n_lines            = n_lines + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // all outputs idle
  task check_idle(input logic [8*16-1:0] tag);
    if (sync_out !== 1'b0)
    begin
      $display("error %0s sync_out expected 0 actual %b", tag, sync_out);
      errors = errors + 1;
    end
    if (pps_valid !== 1'b0)
    begin
      $display("error %0s pps_valid expected 0 actual %b", tag, pps_valid);
      errors = errors + 1;
    end
    if (phase !== '0)
    begin
      $display("error %0s phase expected 0 actual %0d", tag, phase);
      errors = errors + 1;
    end
  endtask

  initial
  begin
    int start;
    int rise_start;
    int prev_phase;
    clk    = 1'b0;
    reset  = 1'b1;
    pps    = 1'b0;
    faster = 1'b0;
    slower = 1'b0;
    read_stim();
    if (n_lines == 0)
    begin
      $display("no stimulus lines were read");
      errors = errors + 1;
    end
    limit = n_lines * (pps_period_cycles + margin_cycles) + 2000;

    // reset seen on 10 rising edges
    repeat (9)
    begin
      @(posedge clk);
      @(negedge clk);
      check_idle("reset");
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle("after_reset");

    start      = 1;  // first interval counts from reset release
    rise_start = 0;
    prev_phase = -1; // no edge yet
    for (int i = 0; i < n_lines; i++)
    begin
      cur_name = names[i];
      rate_on  = (prev_phase == 0) && (ivls[i] == pps_period_cycles) &&
                 (nudges[i] == 0) && (exp_phase[i] == '0);
      for (int c = start; c <= ivls[i]; c++)
      begin
        @(posedge clk);
        if (c == 100)
          pps <= 1'b0; // end of pps pulse
        if (c == 1000 && nudges[i] == 1)
          faster <= 1'b1;
        if (c == 1000 && nudges[i] == 2)
          slower <= 1'b1;
        if (c == 1020)
        begin
          faster <= 1'b0;
          slower <= 1'b0;
        end
        if (c == ivls[i])
        begin
          pps <= 1'b1;
          if (rate_on && (rise_total - rise_start) != pps_period_cycles / sync_div)
          begin
            $display("error %0s sync_rises expected %0d actual %0d", cur_name,
                     pps_period_cycles / sync_div, rise_total - rise_start);
            errors = errors + 1;
          end
          rise_start = rise_total;
        end
      end
      // report is settled 5 cycles after the rise
      repeat (5) @(posedge clk);
      @(negedge clk);
      if (phase !== exp_phase[i])
      begin
        $display("error %0s phase expected %0d actual %0d", cur_name, exp_phase[i], phase);
        errors = errors + 1;
      end
      if (pps_valid !== exp_valid[i])
      begin
        $display("error %0s pps_valid expected %b actual %b", cur_name, exp_valid[i],
                 pps_valid);
        errors = errors + 1;
      end
      prev_phase = int'(exp_phase[i]);
      start      = 6; // 5 cycles of the next interval already gone
    end
    rate_on = 1'b0;

    $display("run done, %0d errors, %0d waveform errors", errors + rate_errors, rate_errors);
    if (errors + rate_errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
